// ==== src/core_pkg.sv ====
package core_pkg;

    // Link dimensions
    localparam int Nti   = 16;
    localparam int Nadc  = 8;
    localparam int Noff  = 8;
    localparam int Nprbs = 7;

    // Datapath types
    typedef logic [Nadc-1:0]        adc_mag_t;
    typedef logic signed [Nadc:0]   lane_code_t;
    typedef logic signed [Noff-1:0] lane_offset_t;
    typedef logic [31:0]            bit_count_t;

    // Wishbone types
    typedef logic [7:0]  wb_addr_t;
    typedef logic [31:0] wb_data_t;

    // PRBS checker operating modes
    typedef enum logic [1:0] {
        CHK_RESET  = 2'd0,
        CHK_ALIGN  = 2'd1,
        CHK_CHECK  = 2'd2,
        CHK_FREEZE = 2'd3
    } checker_mode_t;

    // Register map, byte addresses
    localparam wb_addr_t REG_CTRL        = 8'h00;
    localparam wb_addr_t REG_TOTAL       = 8'h04;
    localparam wb_addr_t REG_CORRECT     = 8'h08;
    localparam wb_addr_t REG_OFFSET_BASE = 8'h40;

endpackage

// ==== src/adc_retimer.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_retimer #(
    parameter int n_lanes = core_pkg::Nti,
    parameter int n_bits  = core_pkg::Nadc
) (
    input  wire logic                clk_adc_i,
    input  wire logic                reset_i,
    input  wire logic [n_bits-1:0]   adcout_i [n_lanes],
    input  wire logic [n_lanes-1:0]  adcout_sign_i,
    output logic      [n_bits-1:0]   aligned_mag_o [n_lanes],
    output logic      [n_lanes-1:0]  aligned_sign_o
);

    localparam int half = n_lanes / 2;

    logic [n_bits-1:0]  mag_q1 [n_lanes];
    logic [n_lanes-1:0] sign_q1;
    logic [n_bits-1:0]  mag_q2 [half];
    logic [half-1:0]    sign_q2;

    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            mag_q1  <= '{default: '0};
            sign_q1 <= '0;
            mag_q2  <= '{default: '0};
            sign_q2 <= '0;
        end else begin
            mag_q1  <= adcout_i;
            sign_q1 <= adcout_sign_i;
            // Lower lanes wait one more capture for their upper half
            for (int k = 0; k < half; k++) begin
                mag_q2[k] <= mag_q1[k];
            end
            sign_q2 <= sign_q1[half-1:0];
        end
    end

    always_comb begin
        for (int k = 0; k < n_lanes; k++) begin
            if (k < half) begin
                aligned_mag_o[k]  = mag_q2[k];
                aligned_sign_o[k] = sign_q2[k];
            end else begin
                aligned_mag_o[k]  = mag_q1[k];
                aligned_sign_o[k] = sign_q1[k];
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/adc_unfolding.sv ====
`timescale 1ns/10ps
`default_nettype none

module adc_unfolding #(
    parameter int n_bits = core_pkg::Nadc,
    parameter int n_off  = core_pkg::Noff
) (
    input  wire logic                   clk_adc_i,
    input  wire logic                   reset_i,
    input  wire core_pkg::adc_mag_t     mag_i,
    input  wire logic                   sign_i,
    input  wire core_pkg::lane_offset_t offset_i,
    output core_pkg::lane_code_t        code_o
);

    import core_pkg::*;

    // Two guard bits cover the sign and the offset subtraction
    localparam int w_sum = ((n_bits > n_off) ? n_bits : n_off) + 2;
    localparam logic signed [w_sum-1:0] code_max = (2 ** n_bits) - 1;
    localparam logic signed [w_sum-1:0] code_min = -(2 ** n_bits);

    logic signed [w_sum-1:0] mag_ext;
    logic signed [w_sum-1:0] off_ext;
    logic signed [w_sum-1:0] signed_val;
    logic signed [w_sum-1:0] diff;
    lane_code_t              code_sat;

    always_comb begin
        mag_ext    = w_sum'(mag_i);
        off_ext    = w_sum'(offset_i);
        signed_val = sign_i ? mag_ext : -mag_ext;
        diff       = signed_val - off_ext;
        if (diff > code_max) begin
            code_sat = lane_code_t'(code_max);
        end else if (diff < code_min) begin
            code_sat = lane_code_t'(code_min);
        end else begin
            code_sat = lane_code_t'(diff);
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            code_o <= '0;
        end else begin
            code_o <= code_sat;
        end
    end

    // Retimer and offset register both settle right after reset
    a_code_known: assert property (@(posedge clk_adc_i) disable iff (reset_i)
        $past(!reset_i) |-> !$isunknown(code_o));

endmodule

`default_nettype wire

// ==== src/prbs_checker.sv ====
`timescale 1ns/10ps
`default_nettype none

module prbs_checker #(
    parameter int n_lanes = core_pkg::Nti,
    parameter int n_prbs  = core_pkg::Nprbs
) (
    input  wire logic                    clk_adc_i,
    input  wire logic                    reset_i,
    input  wire core_pkg::lane_code_t    codes_i [n_lanes],
    input  wire core_pkg::checker_mode_t mode_i,
    output core_pkg::bit_count_t         total_bits_o,
    output core_pkg::bit_count_t         correct_bits_o
);

    import core_pkg::*;

    localparam int cnt_w = $clog2(n_lanes + 1);

    logic [n_lanes-1:0] rx_bits;
    logic [n_lanes-1:0] pred_bits;
    logic [n_prbs-1:0]  state_q;
    logic [n_prbs-1:0]  state_next;
    logic [n_prbs-1:0]  align_state;
    logic [cnt_w-1:0]   match_cnt;
    bit_count_t         total_q;
    bit_count_t         correct_q;

    // Sign decision, zero counts as a one
    always_comb begin
        for (int k = 0; k < n_lanes; k++) begin
            rx_bits[k] = (codes_i[k] >= 0);
        end
    end

    // State bit 0 is the newest symbol
    always_comb begin
        for (int i = 0; i < n_prbs; i++) begin
            align_state[i] = rx_bits[n_lanes-1-i];
        end
    end

    // Run the model across the word, lane 0 first
    always_comb begin
        state_next = state_q;
        for (int k = 0; k < n_lanes; k++) begin
            pred_bits[k] = state_next[n_prbs-1] ^ state_next[n_prbs-2];
            state_next   = {state_next[n_prbs-2:0], pred_bits[k]};
        end
    end

    always_comb begin
        match_cnt = '0;
        for (int k = 0; k < n_lanes; k++) begin
            match_cnt = match_cnt + cnt_w'(pred_bits[k] == rx_bits[k]);
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            state_q   <= '0;
            total_q   <= '0;
            correct_q <= '0;
        end else begin
            case (mode_i)
                CHK_RESET: begin
                    state_q   <= '0;
                    total_q   <= '0;
                    correct_q <= '0;
                end
                CHK_ALIGN: begin
                    state_q <= align_state;
                end
                CHK_CHECK: begin
                    // Advance on predictions so one bad symbol costs one count
                    state_q   <= state_next;
                    total_q   <= total_q + bit_count_t'(n_lanes);
                    correct_q <= correct_q + bit_count_t'(match_cnt);
                end
                default: begin
                    state_q <= state_q;
                end
            endcase
        end
    end

    assign total_bits_o   = total_q;
    assign correct_bits_o = correct_q;

    // Mode comes from the register block and must be defined once out of reset
    a_mode_known: assert property (@(posedge clk_adc_i) disable iff (reset_i)
        !$isunknown(mode_i));

endmodule

`default_nettype wire

// ==== src/wb_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

module wb_regs #(
    parameter int n_lanes = core_pkg::Nti
) (
    input  wire logic                   clk_adc_i,
    input  wire logic                   reset_i,
    input  wire logic                   wb_cyc_i,
    input  wire logic                   wb_stb_i,
    input  wire logic                   wb_we_i,
    input  wire core_pkg::wb_addr_t     wb_adr_i,
    input  wire core_pkg::wb_data_t     wb_dat_i,
    output core_pkg::wb_data_t          wb_dat_o,
    output logic                        wb_ack_o,
    input  wire core_pkg::bit_count_t   total_bits_i,
    input  wire core_pkg::bit_count_t   correct_bits_i,
    output core_pkg::checker_mode_t     checker_mode_o,
    output core_pkg::lane_offset_t      offsets_o [n_lanes]
);

    import core_pkg::*;

    localparam int idx_w = $clog2(n_lanes);

    logic               ack_q;
    logic               req;
    wb_data_t           dat_q;
    wb_data_t           rd_data;
    wb_addr_t           off_rel;
    logic               off_hit;
    logic [idx_w-1:0]   off_idx;
    checker_mode_t      mode_q;
    lane_offset_t       offsets_q [n_lanes];

    // No new request while the ack of the last one is out
    assign req = wb_cyc_i && wb_stb_i && !ack_q;

    // Offset window, one word per lane
    assign off_rel = wb_adr_i - REG_OFFSET_BASE;
    assign off_idx = off_rel[2 +: idx_w];
    assign off_hit = (wb_adr_i >= REG_OFFSET_BASE) && (off_rel[1:0] == 2'b00)
                     && ((off_rel >> 2) < n_lanes);

    always_comb begin
        rd_data = '0;
        if (wb_adr_i == REG_CTRL) begin
            rd_data = wb_data_t'(mode_q);
        end else if (wb_adr_i == REG_TOTAL) begin
            rd_data = total_bits_i;
        end else if (wb_adr_i == REG_CORRECT) begin
            rd_data = correct_bits_i;
        end else if (off_hit) begin
            rd_data = wb_data_t'($unsigned(offsets_q[off_idx]));
        end
    end

    always_ff @(posedge clk_adc_i) begin
        if (reset_i) begin
            ack_q     <= 1'b0;
            mode_q    <= CHK_RESET;
            offsets_q <= '{default: '0};
        end else begin
            ack_q <= req;
            if (req && wb_we_i) begin
                if (wb_adr_i == REG_CTRL) begin
                    mode_q <= checker_mode_t'(wb_dat_i[1:0]);
                end
                if (off_hit) begin
                    offsets_q[off_idx] <= lane_offset_t'(wb_dat_i[Noff-1:0]);
                end
            end
        end
    end

    // Read data travels with the ack
    always_ff @(posedge clk_adc_i) begin
        if (req) begin
            dat_q <= rd_data;
        end
    end

    assign wb_ack_o       = ack_q;
    assign wb_dat_o       = dat_q;
    assign checker_mode_o = mode_q;
    assign offsets_o      = offsets_q;

    a_ack_after_cyc: assert property (@(posedge clk_adc_i) disable iff (reset_i)
        wb_ack_o |-> $past(wb_cyc_i));

    a_ack_single: assert property (@(posedge clk_adc_i) disable iff (reset_i)
        wb_ack_o |=> !wb_ack_o);

endmodule

`default_nettype wire

// ==== src/digital_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module digital_core #(
    parameter int n_lanes = core_pkg::Nti,
    parameter int n_bits  = core_pkg::Nadc
) (
    input  wire logic                clk_adc_i,
    input  wire logic                reset_i,
    input  wire core_pkg::adc_mag_t  adcout_i [n_lanes],
    input  wire logic [n_lanes-1:0]  adcout_sign_i,
    input  wire logic                wb_cyc_i,
    input  wire logic                wb_stb_i,
    input  wire logic                wb_we_i,
    input  wire core_pkg::wb_addr_t  wb_adr_i,
    input  wire core_pkg::wb_data_t  wb_dat_i,
    output core_pkg::wb_data_t       wb_dat_o,
    output logic                     wb_ack_o
);

    import core_pkg::*;

    adc_mag_t           aligned_mag [n_lanes];
    logic [n_lanes-1:0] aligned_sign;
    lane_code_t         unfolded [n_lanes];
    lane_offset_t       offsets [n_lanes];
    checker_mode_t      checker_mode;
    bit_count_t         total_bits;
    bit_count_t         correct_bits;

    // Staggered sub-ADC lanes into one symbol word
    adc_retimer #(
        .n_lanes (n_lanes),
        .n_bits  (n_bits)
    ) i_retimer (
        .clk_adc_i      (clk_adc_i),
        .reset_i        (reset_i),
        .adcout_i       (adcout_i),
        .adcout_sign_i  (adcout_sign_i),
        .aligned_mag_o  (aligned_mag),
        .aligned_sign_o (aligned_sign)
    );

    for (genvar k = 0; k < n_lanes; k++) begin : lane_slice
        adc_unfolding #(
            .n_bits (n_bits),
            .n_off  (Noff)
        ) i_unfold (
            .clk_adc_i (clk_adc_i),
            .reset_i   (reset_i),
            .mag_i     (aligned_mag[k]),
            .sign_i    (aligned_sign[k]),
            .offset_i  (offsets[k]),
            .code_o    (unfolded[k])
        );
    end

    prbs_checker #(
        .n_lanes (n_lanes),
        .n_prbs  (Nprbs)
    ) i_checker (
        .clk_adc_i      (clk_adc_i),
        .reset_i        (reset_i),
        .codes_i        (unfolded),
        .mode_i         (checker_mode),
        .total_bits_o   (total_bits),
        .correct_bits_o (correct_bits)
    );

    // Software access to offsets, mode and counters
    wb_regs #(
        .n_lanes (n_lanes)
    ) i_regs (
        .clk_adc_i      (clk_adc_i),
        .reset_i        (reset_i),
        .wb_cyc_i       (wb_cyc_i),
        .wb_stb_i       (wb_stb_i),
        .wb_we_i        (wb_we_i),
        .wb_adr_i       (wb_adr_i),
        .wb_dat_i       (wb_dat_i),
        .wb_dat_o       (wb_dat_o),
        .wb_ack_o       (wb_ack_o),
        .total_bits_i   (total_bits),
        .correct_bits_i (correct_bits),
        .checker_mode_o (checker_mode),
        .offsets_o      (offsets)
    );

endmodule

`default_nettype wire

// ==== tests/tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 2
) (
    output logic clk_o,
    output logic reset_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(period_ns / 2.0);
            clk_o = ~clk_o;
        end
    end

    // Released just after an edge, like the rest of the stimulus
    initial begin
        reset_o = 1'b1;
        repeat (reset_cycles) @(posedge clk_o);
        #1;
        reset_o = 1'b0;
    end

endmodule

// ==== tests/tb_digital_core.sv ====
`timescale 1ns/10ps

module tb_digital_core;

    import core_pkg::*;

    localparam int clk_period      = 8;
    localparam int watchdog_cycles = 6 * 2000;
    localparam int ack_limit       = 16;

    logic           clk;
    logic           por_reset;
    logic           force_reset;
    logic           reset;
    adc_mag_t       adcout [Nti];
    logic [Nti-1:0] adcout_sign;
    logic           wb_cyc;
    logic           wb_stb;
    logic           wb_we;
    wb_addr_t       wb_adr;
    wb_data_t       wb_dat_w;
    wb_data_t       wb_dat_r;
    logic           wb_ack;

    // Stream model state and knobs the tests turn
    logic [Nprbs-1:0] prbs_hist;
    logic [Nti-1:0]   word_cur;
    logic [Nti-1:0]   word_next;
    logic [Nti-1:0]   flip_mask;
    int               mag_min;
    int               mag_max;
    int               lane5_mag;
    int               errors;
    int               pass_count;
    int               fail_count;

    assign reset = por_reset || force_reset;

    tb_clock #(
        .period_ns    (clk_period),
        .reset_cycles (2)
    ) i_clock (
        .clk_o   (clk),
        .reset_o (por_reset)
    );

    digital_core #(
        .n_lanes (Nti),
        .n_bits  (Nadc)
    ) i_dut (
        .clk_adc_i     (clk),
        .reset_i       (reset),
        .adcout_i      (adcout),
        .adcout_sign_i (adcout_sign),
        .wb_cyc_i      (wb_cyc),
        .wb_stb_i      (wb_stb),
        .wb_we_i       (wb_we),
        .wb_adr_i      (wb_adr),
        .wb_dat_i      (wb_dat_w),
        .wb_dat_o      (wb_dat_r),
        .wb_ack_o      (wb_ack)
    );

    // PRBS7 x^7 + x^6 + 1 with lane 0 as the earliest symbol
    task automatic advance_prbs(output logic [Nti-1:0] word);
        logic nb;
        for (int k = 0; k < Nti; k++) begin
            nb = prbs_hist[6] ^ prbs_hist[5];
            prbs_hist = {prbs_hist[5:0], nb};
            word[k] = nb;
        end
    endtask

    function automatic int pick_mag(input int lane);
        if (lane == 5 && lane5_mag >= 0) begin
            return lane5_mag;
        end
        return mag_min + int'($urandom % (mag_max - mag_min + 1));
    endfunction

    // Lower lanes of a word go out one capture ahead of its upper lanes
    always @(posedge clk) begin
        logic [Nti-1:0] gen_word;
        #1;
        word_cur = word_next;
        advance_prbs(gen_word);
        word_next = gen_word ^ flip_mask;
        flip_mask = '0;
        for (int k = 0; k < Nti; k++) begin
            adcout[k] = adc_mag_t'(pick_mag(k));
            adcout_sign[k] = (k < Nti / 2) ? word_next[k] : word_cur[k];
        end
    end

    task automatic wb_access(input logic we, input wb_addr_t adr, input wb_data_t wdata,
                             output wb_data_t rdata);
        int waited;
        @(posedge clk);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdata;
        waited   = 0;
        rdata    = '0;
        do begin
            @(posedge clk);
            #1;
            waited++;
        end while (!wb_ack && waited < ack_limit);
        if (wb_ack) begin
            rdata = wb_dat_r;
        end else begin
            $display("No Wishbone ack within %0d cycles for address 0x%02h", ack_limit, adr);
            errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input wb_addr_t adr, input wb_data_t data);
        wb_data_t unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input wb_addr_t adr, output wb_data_t data);
        wb_access(1'b0, adr, '0, data);
    endtask

    task automatic check_eq(input string what, input longint got, input longint exp);
        assert (got == exp) else begin
            $display("MISMATCH at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input string what, input bit cond);
        assert (cond) else begin
            $display("MISMATCH at %0t ns: %s", $time, what);
            errors++;
        end
    endtask

    task automatic set_mode(input checker_mode_t m);
        wb_write(REG_CTRL, wb_data_t'(m));
    endtask

    task automatic read_counts(output bit_count_t total, output bit_count_t correct);
        wb_read(REG_TOTAL, total);
        wb_read(REG_CORRECT, correct);
    endtask

    task automatic run_link(input int check_cycles, output bit_count_t total,
                            output bit_count_t correct);
        set_mode(CHK_RESET);
        set_mode(CHK_ALIGN);
        repeat (10) @(posedge clk);
        set_mode(CHK_CHECK);
        repeat (check_cycles) @(posedge clk);
        set_mode(CHK_FREEZE);
        read_counts(total, correct);
    endtask

    task automatic inject_flips(input logic [Nti-1:0] mask);
        @(posedge clk);
        flip_mask = mask;
    endtask

    task automatic report_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            pass_count++;
            $display("%s: pass", name);
        end else begin
            fail_count++;
            $display("%s: FAIL with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic test_register_access();
        int       e0;
        wb_data_t rd;
        logic [7:0] val;
        e0 = errors;
        wb_read(REG_CTRL, rd);
        check_eq("mode after reset", rd, 0);
        wb_read(REG_TOTAL, rd);
        check_eq("total after reset", rd, 0);
        wb_read(REG_CORRECT, rd);
        check_eq("correct after reset", rd, 0);
        for (int k = 0; k < Nti; k++) begin
            wb_read(REG_OFFSET_BASE + wb_addr_t'(4 * k), rd);
            check_eq($sformatf("offset %0d after reset", k), rd, 0);
            val = 8'(k * 29 + 3);
            wb_write(REG_OFFSET_BASE + wb_addr_t'(4 * k), 32'hFFFF_FF00 | val);
        end
        for (int k = 0; k < Nti; k++) begin
            wb_read(REG_OFFSET_BASE + wb_addr_t'(4 * k), rd);
            val = 8'(k * 29 + 3);
            check_eq($sformatf("offset %0d readback", k), rd, val);
            wb_write(REG_OFFSET_BASE + wb_addr_t'(4 * k), 32'h0);
        end
        wb_write(8'h20, 32'hDEAD_BEEF);
        wb_read(8'h20, rd);
        check_eq("unmapped 0x20", rd, 0);
        wb_read(8'h80, rd);
        check_eq("unmapped 0x80", rd, 0);
        report_test("register_access", e0);
    endtask

    task automatic test_clean_lock();
        int         e0;
        bit_count_t total;
        bit_count_t correct;
        e0 = errors;
        run_link(200, total, correct);
        check_eq("clean lock correct", correct, total);
        check_true("total nonzero multiple of lanes", total != 0 && total % Nti == 0);
        report_test("clean_lock", e0);
    endtask

    task automatic test_counted_errors();
        int         e0;
        bit_count_t total;
        bit_count_t correct;
        bit_count_t total2;
        bit_count_t correct2;
        e0 = errors;
        set_mode(CHK_RESET);
        set_mode(CHK_ALIGN);
        repeat (10) @(posedge clk);
        set_mode(CHK_CHECK);
        repeat (40) @(posedge clk);
        inject_flips(16'h0001);
        repeat (40) @(posedge clk);
        inject_flips(16'h8420);
        repeat (40) @(posedge clk);
        inject_flips(16'h0180);
        repeat (80) @(posedge clk);
        set_mode(CHK_FREEZE);
        read_counts(total, correct);
        check_eq("error count", total - correct, 6);
        repeat (50) @(posedge clk);
        read_counts(total2, correct2);
        check_eq("frozen total", total2, total);
        check_eq("frozen correct", correct2, correct);
        report_test("counted_errors", e0);
    endtask

    task automatic test_offset_saturation();
        int         e0;
        bit_count_t total;
        bit_count_t correct;
        wb_addr_t   lane5_adr;
        e0 = errors;
        lane5_adr = REG_OFFSET_BASE + 8'd20;
        mag_min = 200;
        wb_write(lane5_adr, 32'd127);
        run_link(200, total, correct);
        check_eq("offset 127, large magnitudes", total - correct, 0);
        // Small lane 5 symbols flip sign under the offset
        mag_min = 128;
        lane5_mag = 20;
        run_link(200, total, correct);
        check_true("offset 127 errors limited to lane 5",
                   total != correct && (total - correct) <= total / Nti);
        wb_write(lane5_adr, 32'h80);
        run_link(200, total, correct);
        check_true("offset -128 errors limited to lane 5",
                   total != correct && (total - correct) <= total / Nti);
        lane5_mag = -1;
        wb_write(lane5_adr, 32'h0);
        report_test("offset_saturation", e0);
    endtask

    task automatic test_mode_reset();
        int         e0;
        bit_count_t total;
        bit_count_t correct;
        wb_data_t   rd;
        e0 = errors;
        set_mode(CHK_ALIGN);
        repeat (10) @(posedge clk);
        set_mode(CHK_CHECK);
        repeat (60) @(posedge clk);
        set_mode(CHK_RESET);
        read_counts(total, correct);
        check_eq("total after mode reset", total, 0);
        check_eq("correct after mode reset", correct, 0);
        set_mode(CHK_ALIGN);
        repeat (10) @(posedge clk);
        set_mode(CHK_CHECK);
        repeat (60) @(posedge clk);
        @(posedge clk);
        #1;
        force_reset = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        force_reset = 1'b0;
        read_counts(total, correct);
        check_eq("total after reset_i", total, 0);
        check_eq("correct after reset_i", correct, 0);
        wb_read(REG_CTRL, rd);
        check_eq("mode after reset_i", rd, 0);
        run_link(200, total, correct);
        check_true("relock counts nonzero", total != 0);
        check_eq("relock correct", correct, total);
        report_test("mode_reset", e0);
    endtask

    initial begin
        void'($urandom(32'haec4_7870));
        force_reset = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_adr      = '0;
        wb_dat_w    = '0;
        adcout      = '{default: '0};
        adcout_sign = '0;
        flip_mask   = '0;
        prbs_hist   = '1;
        word_cur    = '0;
        word_next   = '0;
        mag_min     = 128;
        mag_max     = 255;
        lane5_mag   = -1;
        errors      = 0;
        pass_count  = 0;
        fail_count  = 0;
        wait (!por_reset);
        repeat (2) @(posedge clk);
        test_register_access();
        test_clean_lock();
        test_counted_errors();
        test_offset_saturation();
        test_mode_reset();
        $display("pass count %0d, fail count %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("Timeout: the run did not finish within %0d cycles", watchdog_cycles);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
src/core_pkg.sv
src/adc_retimer.sv
src/adc_unfolding.sv
src/prbs_checker.sv
src/wb_regs.sv
src/digital_core.sv
tests/tb_clock.sv
tests/tb_digital_core.sv
